// ==== hdl/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // default machine sizes, mirrored by the rename_core parameters
    localparam int ARCH_REGS   = 8;
    localparam int PHY_REGS    = 16;
    localparam int ROB_ENTRIES = 8;

    // architectural register index
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_t;

    // physical register index
    typedef logic [$clog2(PHY_REGS)-1:0] phy_t;

    // reorder buffer slot, also the writeback tag
    typedef logic [$clog2(ROB_ENTRIES)-1:0] rob_id_t;

endpackage

`default_nettype wire

// ==== hdl/rename_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_map #(
    parameter int ARCH_REGS = rename_pkg::ARCH_REGS
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               alloc_en,
    input  rename_pkg::arch_t  alloc_rd,
    input  rename_pkg::phy_t   alloc_phy,
    output rename_pkg::phy_t   old_phy,
    input  logic               commit_en,
    input  rename_pkg::arch_t  commit_rd,
    input  rename_pkg::phy_t   commit_phy
);

    import rename_pkg::*;

    // speculative mapping seen by rename
    phy_t front_map [ARCH_REGS];
    // mapping of retired instructions only
    phy_t back_map  [ARCH_REGS];

    // previous owner of rd, kept in the ROB so it can be freed at retire
    assign old_phy = front_map[alloc_rd];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                front_map[i] <= phy_t'(i);
            end
        end else if (flush) begin
            // drop every speculative rename
            for (int i = 0; i < ARCH_REGS; i++) begin
                front_map[i] <= back_map[i];
            end
        end else if (alloc_en) begin
            front_map[alloc_rd] <= alloc_phy;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                back_map[i] <= phy_t'(i);
            end
        end else if (commit_en) begin
            back_map[commit_rd] <= commit_phy;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list #(
    parameter int ARCH_REGS = rename_pkg::ARCH_REGS,
    parameter int PHY_REGS  = rename_pkg::PHY_REGS
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              pop,
    output rename_pkg::phy_t  head_phy,
    output logic              empty,
    input  logic              push,
    input  rename_pkg::phy_t  push_phy
);

    import rename_pkg::*;

    // registers above the architectural ones form the pool
    localparam int DEPTH = PHY_REGS - ARCH_REGS;
    localparam int IDX_W = $clog2(DEPTH);
    // one extra wrap bit so a full queue differs from an empty one
    localparam int PTR_W = IDX_W + 1;

    phy_t             fl_mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] commit_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] count;

    assign head_phy = fl_mem[rd_ptr[IDX_W-1:0]];
    assign empty    = (count == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr     <= '0;
            commit_ptr <= '0;
            wr_ptr     <= PTR_W'(DEPTH);
            count      <= PTR_W'(DEPTH);
        end else if (flush) begin
            // speculative pops are undone, the pool is whatever is not committed
            rd_ptr <= commit_ptr;
            count  <= wr_ptr - commit_ptr;
        end else begin
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // a push is a retire, which also commits one earlier pop
            if (push) begin
                wr_ptr     <= wr_ptr + 1'b1;
                commit_ptr <= commit_ptr + 1'b1;
            end
            count <= count + PTR_W'(push) - PTR_W'(pop);
        end
    end

    // initial pool ARCH_REGS .. PHY_REGS-1 in ascending order
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                fl_mem[i] <= phy_t'(ARCH_REGS + i);
            end
        end else if (push && !flush) begin
            fl_mem[wr_ptr[IDX_W-1:0]] <= push_phy;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_ENTRIES = rename_pkg::ROB_ENTRIES
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                alloc_en,
    input  rename_pkg::arch_t   alloc_rd,
    input  rename_pkg::phy_t    alloc_phy,
    input  rename_pkg::phy_t    alloc_old_phy,
    input  logic                alloc_mispredict,
    output rename_pkg::rob_id_t tail_id,
    output logic                full,
    input  logic                wb_valid,
    input  rename_pkg::rob_id_t wb_rob_id,
    output logic                retire_valid,
    output rename_pkg::arch_t   retire_rd,
    output rename_pkg::phy_t    retire_phy_new,
    output rename_pkg::phy_t    retire_phy_old,
    output logic                retire_mispredict
);

    import rename_pkg::*;

    localparam int CNT_W = $clog2(ROB_ENTRIES + 1);

    // entry payload
    arch_t                  rob_rd      [ROB_ENTRIES];
    phy_t                   rob_phy_new [ROB_ENTRIES];
    phy_t                   rob_phy_old [ROB_ENTRIES];
    logic [ROB_ENTRIES-1:0] rob_mispredict;

    // completion flags
    logic [ROB_ENTRIES-1:0] rob_done;

    rob_id_t    head;
    rob_id_t    tail;
    logic [CNT_W-1:0] count;
    logic       rob_empty;

    assign rob_empty = (count == '0);
    assign full      = (count == CNT_W'(ROB_ENTRIES));
    assign tail_id   = tail;

    // oldest entry leaves once it has written back
    assign retire_valid      = !rob_empty && rob_done[head] && !flush;
    assign retire_rd         = rob_rd[head];
    assign retire_phy_new    = rob_phy_new[head];
    assign retire_phy_old    = rob_phy_old[head];
    assign retire_mispredict = rob_mispredict[head];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // everything still in flight is younger than the mispredict
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_en) begin
                tail <= tail + 1'b1;
            end
            if (retire_valid) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(alloc_en) - CNT_W'(retire_valid);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rob_done <= '0;
        end else if (!flush) begin
            if (wb_valid) begin
                rob_done[wb_rob_id] <= 1'b1;
            end
            // tail slot is never in flight, so this cannot clash with a writeback
            if (alloc_en) begin
                rob_done[tail] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            rob_rd[tail]         <= alloc_rd;
            rob_phy_new[tail]    <= alloc_phy;
            rob_phy_old[tail]    <= alloc_old_phy;
            rob_mispredict[tail] <= alloc_mispredict;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rename_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_core #(
    parameter int ARCH_REGS   = rename_pkg::ARCH_REGS,
    parameter int PHY_REGS    = rename_pkg::PHY_REGS,
    parameter int ROB_ENTRIES = rename_pkg::ROB_ENTRIES
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rename_valid,
    input  rename_pkg::arch_t   rename_rd,
    input  logic                rename_mispredict,
    output logic                stall,
    output rename_pkg::phy_t    rename_phy,
    output rename_pkg::rob_id_t rename_rob_id,
    input  logic                wb_valid,
    input  rename_pkg::rob_id_t wb_rob_id,
    output logic                retire_valid,
    output rename_pkg::arch_t   retire_rd,
    output rename_pkg::phy_t    retire_phy_new,
    output rename_pkg::phy_t    retire_phy_old,
    output logic                flush
);

    import rename_pkg::*;

    logic fl_empty;
    logic rob_full;
    logic accept;
    logic retire_mispredict;
    phy_t old_phy;

    // no renames while out of resources or while recovering
    assign stall  = fl_empty || rob_full || flush;
    assign accept = rename_valid && !stall;

    // one-cycle recovery pulse after a mispredicted branch retires
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flush <= 1'b0;
        end else begin
            flush <= retire_valid && retire_mispredict;
        end
    end

    rename_map #(
        .ARCH_REGS(ARCH_REGS)
    ) rename_map_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .alloc_en(accept),
        .alloc_rd(rename_rd),
        .alloc_phy(rename_phy),
        .old_phy(old_phy),
        .commit_en(retire_valid),
        .commit_rd(retire_rd),
        .commit_phy(retire_phy_new)
    );

    free_list #(
        .ARCH_REGS(ARCH_REGS),
        .PHY_REGS(PHY_REGS)
    ) free_list_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .pop(accept),
        .head_phy(rename_phy),
        .empty(fl_empty),
        .push(retire_valid),
        .push_phy(retire_phy_old)
    );

    reorder_buffer #(
        .ROB_ENTRIES(ROB_ENTRIES)
    ) reorder_buffer_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .alloc_en(accept),
        .alloc_rd(rename_rd),
        .alloc_phy(rename_phy),
        .alloc_old_phy(old_phy),
        .alloc_mispredict(rename_mispredict),
        .tail_id(rename_rob_id),
        .full(rob_full),
        .wb_valid(wb_valid),
        .wb_rob_id(wb_rob_id),
        .retire_valid(retire_valid),
        .retire_rd(retire_rd),
        .retire_phy_new(retire_phy_new),
        .retire_phy_old(retire_phy_old),
        .retire_mispredict(retire_mispredict)
    );

endmodule

`default_nettype wire

// ==== testbench/rename_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_core_properties (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,
    input logic retire_valid
);

    // recovery cycle blocks new renames
    assert property (@(posedge clk) disable iff (rst) flush |-> stall)
        else $error("stall low while flush is high");

    // the ROB is being emptied, nothing may leave it
    assert property (@(posedge clk) disable iff (rst) flush |-> !retire_valid)
        else $error("retire_valid high during flush");

    // flush is a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst) flush |=> !flush)
        else $error("flush high on two consecutive cycles");

endmodule

bind rename_core rename_core_properties rename_core_properties_i (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .flush(flush),
    .retire_valid(retire_valid)
);

`default_nettype wire

// ==== testbench/rename_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb;

    import rename_pkg::*;

    logic clk, rst, rename_valid, rename_mispredict, wb_valid;
    arch_t rename_rd;
    rob_id_t wb_rob_id;
    logic stall, retire_valid, flush;
    phy_t rename_phy, retire_phy_new, retire_phy_old;
    rob_id_t rename_rob_id;
    arch_t retire_rd;

    // one word per cycle holding test, valid, rd, mispredict, wb_valid, wb_rob_id
    logic [23:0] stim [0:127];
    int n_lines, line_idx, cycle, limit, tail_cycles, errors, checks;
    int cur_test, test_checks, test_errors, accepted;
    bit timed_out;

    // reference model state
    phy_t front [ARCH_REGS];
    phy_t back [ARCH_REGS];
    phy_t fl_all [$];
    int spec_pops, rob_head, idx;
    arch_t rob_rd_q [$];
    phy_t rob_new_q [$];
    phy_t rob_old_q [$];
    bit rob_mis_q [$];
    bit rob_done_q [$];
    bit model_flush, exp_stall, exp_retire, take;
    arch_t pend_rd [$];
    bit pend_mis [$];

    rename_core #(
        .ARCH_REGS(ARCH_REGS),
        .PHY_REGS(PHY_REGS),
        .ROB_ENTRIES(ROB_ENTRIES)
    ) rename_core_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare_field(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[FAIL] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test();
        $display("test %0d finished: %0d checks, %0d errors", cur_test, test_checks,
                 test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        // unused words carry test number f and their own address
        for (int i = 0; i < 128; i++) begin
            stim[i] = 24'hf00000 | 24'(i);
        end
        $readmemh("testbench/rename_core_input.txt", stim);
        n_lines = 0;
        while (n_lines < 128 && stim[n_lines] !== (24'hf00000 | 24'(n_lines))) begin
            n_lines++;
        end
        limit = n_lines + 20;
        rst = 1'b1;
        rename_valid = 1'b0;
        rename_rd = '0;
        rename_mispredict = 1'b0;
        wb_valid = 1'b0;
        wb_rob_id = '0;
        errors = 0;
        checks = 0;
        test_checks = 0;
        test_errors = 0;
        accepted = 0;
        timed_out = 1'b0;
        cur_test = stim[0][23:20];
        for (int i = 0; i < ARCH_REGS; i++) begin
            front[i] = phy_t'(i);
            back[i] = phy_t'(i);
        end
        for (int i = ARCH_REGS; i < PHY_REGS; i++) fl_all.push_back(phy_t'(i));
        spec_pops = 0;
        rob_head = 0;
        model_flush = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        line_idx = 0;
        cycle = 0;
        tail_cycles = 0;
        while (!(line_idx >= n_lines && pend_rd.size() == 0 && tail_cycles >= 4)) begin
            if (cycle >= limit) begin
                timed_out = 1'b1;
                break;
            end
            @(negedge clk);
            wb_valid = 1'b0;
            if (line_idx < n_lines) begin
                if (int'(stim[line_idx][23:20]) != cur_test) begin
                    report_test();
                    cur_test = stim[line_idx][23:20];
                end
                if (stim[line_idx][16]) begin
                    pend_rd.push_back(stim[line_idx][14:12]);
                    pend_mis.push_back(stim[line_idx][8]);
                end
                wb_valid = stim[line_idx][4];
                wb_rob_id = stim[line_idx][2:0];
                line_idx++;
            end else if (pend_rd.size() == 0) begin
                tail_cycles++;
            end
            rename_valid = (pend_rd.size() != 0);
            rename_rd = rename_valid ? pend_rd[0] : '0;
            rename_mispredict = rename_valid ? pend_mis[0] : 1'b0;
            #10;
            // expected outputs for this cycle
            exp_stall = (spec_pops == fl_all.size()) ||
                        (rob_rd_q.size() == ROB_ENTRIES) || model_flush;
            exp_retire = (rob_rd_q.size() != 0) && rob_done_q[0] && !model_flush;
            compare_field("flush", flush, model_flush);
            compare_field("stall", stall, exp_stall);
            compare_field("rename_rob_id", rename_rob_id,
                          (rob_head + rob_rd_q.size()) % ROB_ENTRIES);
            if (spec_pops < fl_all.size()) begin
                compare_field("rename_phy", rename_phy, fl_all[spec_pops]);
            end
            compare_field("retire_valid", retire_valid, exp_retire);
            if (exp_retire) begin
                compare_field("retire_rd", retire_rd, rob_rd_q[0]);
                compare_field("retire_phy_new", retire_phy_new, rob_new_q[0]);
                compare_field("retire_phy_old", retire_phy_old, rob_old_q[0]);
            end
            // state after the coming rising edge
            take = rename_valid && !exp_stall;
            if (model_flush) begin
                for (int i = 0; i < ARCH_REGS; i++) front[i] = back[i];
                spec_pops = 0;
                rob_rd_q.delete();
                rob_new_q.delete();
                rob_old_q.delete();
                rob_mis_q.delete();
                rob_done_q.delete();
                rob_head = 0;
                model_flush = 1'b0;
            end else begin
                if (wb_valid) begin
                    idx = (int'(wb_rob_id) - rob_head + ROB_ENTRIES) % ROB_ENTRIES;
                    if (idx < rob_rd_q.size()) rob_done_q[idx] = 1'b1;
                end
                if (take) begin
                    rob_rd_q.push_back(rename_rd);
                    rob_new_q.push_back(fl_all[spec_pops]);
                    rob_old_q.push_back(front[rename_rd]);
                    rob_mis_q.push_back(rename_mispredict);
                    rob_done_q.push_back(1'b0);
                    front[rename_rd] = fl_all[spec_pops];
                    spec_pops++;
                end
                model_flush = exp_retire && rob_mis_q[0];
                if (exp_retire) begin
                    back[rob_rd_q[0]] = rob_new_q[0];
                    void'(fl_all.pop_front());
                    fl_all.push_back(rob_old_q[0]);
                    spec_pops--;
                    void'(rob_rd_q.pop_front());
                    void'(rob_new_q.pop_front());
                    void'(rob_old_q.pop_front());
                    void'(rob_mis_q.pop_front());
                    void'(rob_done_q.pop_front());
                    rob_head = (rob_head + 1) % ROB_ENTRIES;
                end
            end
            if (take) begin
                accepted++;
                void'(pend_rd.pop_front());
                void'(pend_mis.pop_front());
            end
            cycle++;
        end
        if (timed_out) begin
            $display("timeout: run did not finish within %0d cycles", limit);
        end
        report_test();
        $display("%0d checks, %0d errors, %0d renames accepted", checks, errors, accepted);
        if (errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/rename_core_input.txt ====
// digits: test, rename_valid, rd, mispredict, wb_valid, wb_rob_id
// one line per cycle after reset
1_1_1_0_0_0
1_1_2_0_0_0
1_1_3_0_0_0
2_0_0_0_1_2
2_0_0_0_1_0
2_0_0_0_1_1
2_0_0_0_0_0
2_0_0_0_0_0
2_0_0_0_0_0
3_1_4_0_0_0
3_1_4_0_0_0
3_1_4_0_0_0
3_1_4_0_0_0
3_1_4_0_0_0
3_1_4_0_0_0
4_1_5_0_0_0
4_1_5_0_0_0
4_1_6_0_0_0
4_0_0_0_1_3
4_0_0_0_0_0
4_0_0_0_0_0
4_0_0_0_1_4
4_0_0_0_1_5
4_0_0_0_1_6
4_0_0_0_1_7
4_0_0_0_1_0
4_0_0_0_1_1
4_0_0_0_1_2
4_0_0_0_1_3
4_0_0_0_0_0
4_0_0_0_0_0
5_1_1_1_0_0
5_1_2_0_0_0
5_1_3_0_1_5
5_0_0_0_1_4
5_0_0_0_0_0
5_1_2_0_0_0
5_0_0_0_0_0
5_1_3_0_0_0
5_0_0_0_1_0
5_0_0_0_1_1
5_0_0_0_0_0
5_0_0_0_0_0

// ==== rename_core.f ====
hdl/rename_pkg.sv
hdl/rename_map.sv
hdl/free_list.sv
hdl/reorder_buffer.sv
hdl/rename_core.sv
testbench/rename_core_properties.sv
testbench/rename_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rename core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module rename_core_tb -f rename_core.f; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vrename_core_tb)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
exit 1
